// File: rtl/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_tag_t;
    typedef logic [1:0]  byte_off_t;

    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    localparam addr_t SRAM_BASE  = 32'h8000_0000;
    localparam int    SRAM_WORDS = 256;
    localparam int    SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam addr_t SRAM_BYTES = addr_t'(SRAM_WORDS * 4);

    typedef logic [SRAM_IDX_W-1:0] sram_idx_t; // word index inside the array.

endpackage

`default_nettype wire

// File: rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [1:0] axi_resp_t;
    typedef logic [3:0] axi_strb_t;

    localparam axi_size_t SIZE_BYTE = 3'd0;
    localparam axi_size_t SIZE_HALF = 3'd1;
    localparam axi_size_t SIZE_WORD = 3'd2;

    localparam axi_burst_t BURST_INCR = 2'b01;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    localparam axi_len_t LEN_SINGLE  = 8'd0;
    localparam axi_id_t  LSU_AXI_ID  = 4'h1; // id used by the load/store unit.

endpackage

`default_nettype wire

// File: rtl/axi_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_if;

    logic                 awvalid;
    logic                 awready;
    axi_pkg::axi_id_t     awid;
    mem_types_pkg::addr_t awaddr;
    axi_pkg::axi_len_t    awlen;
    axi_pkg::axi_size_t   awsize;
    axi_pkg::axi_burst_t  awburst;

    logic                 wvalid;
    logic                 wready;
    mem_types_pkg::data_t wdata;
    axi_pkg::axi_strb_t   wstrb;
    logic                 wlast;

    logic                 bvalid;
    logic                 bready;
    axi_pkg::axi_id_t     bid;
    axi_pkg::axi_resp_t   bresp;

    logic                 arvalid;
    logic                 arready;
    axi_pkg::axi_id_t     arid;
    mem_types_pkg::addr_t araddr;
    axi_pkg::axi_len_t    arlen;
    axi_pkg::axi_size_t   arsize;
    axi_pkg::axi_burst_t  arburst;

    logic                 rvalid;
    logic                 rready;
    axi_pkg::axi_id_t     rid;
    mem_types_pkg::data_t rdata;
    axi_pkg::axi_resp_t   rresp;
    logic                 rlast;

    modport master (
        output awvalid, awid, awaddr, awlen, awsize, awburst,
        output wvalid, wdata, wstrb, wlast, bready,
        output arvalid, arid, araddr, arlen, arsize, arburst, rready,
        input  awready, wready, bvalid, bid, bresp,
        input  arready, rvalid, rid, rdata, rresp, rlast
    );

    modport slave (
        input  awvalid, awid, awaddr, awlen, awsize, awburst,
        input  wvalid, wdata, wstrb, wlast, bready,
        input  arvalid, arid, araddr, arlen, arsize, arburst, rready,
        output awready, wready, bvalid, bid, bresp,
        output arready, rvalid, rid, rdata, rresp, rlast
    );

endinterface

`default_nettype wire

// File: rtl/mem_stage_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic                     valid;
    logic                     ready;
    mem_types_pkg::addr_t     addr;
    mem_types_pkg::mem_op_e   op;
    mem_types_pkg::data_t     wdata;
    mem_types_pkg::reg_tag_t  tag;
    logic                     misaligned;

    modport source (output valid, addr, op, wdata, tag, misaligned, input ready);
    modport sink   (input valid, addr, op, wdata, tag, misaligned, output ready);

endinterface

interface mem_rsp_if;

    logic                     valid;
    logic                     ready;
    mem_types_pkg::data_t     rdata;  // raw bus word, not yet shifted.
    mem_types_pkg::mem_op_e   op;
    mem_types_pkg::byte_off_t offset;
    mem_types_pkg::reg_tag_t  tag;
    logic                     fault;

    modport source (output valid, rdata, op, offset, tag, fault, input ready);
    modport sink   (input valid, rdata, op, offset, tag, fault, output ready);

endinterface

`default_nettype wire

// File: rtl/agu.sv
`timescale 1ns/1ps
`default_nettype none

module agu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  mem_types_pkg::mem_op_e  req_op,
    input  mem_types_pkg::data_t    req_base,
    input  mem_types_pkg::data_t    req_offset,
    input  mem_types_pkg::data_t    req_wdata,
    input  mem_types_pkg::reg_tag_t req_tag,
    mem_req_if.source               out
);

    mem_types_pkg::addr_t sum;
    logic                 misaligned;

    assign sum = req_base + req_offset;

    always_comb begin
        case (req_op)
            mem_types_pkg::op_lh,
            mem_types_pkg::op_lhu,
            mem_types_pkg::op_sh: misaligned = sum[0];
            mem_types_pkg::op_lw,
            mem_types_pkg::op_sw: misaligned = (sum[1:0] != 2'b00);
            default:              misaligned = 1'b0;
        endcase
    end

    assign req_ready = !out.valid || out.ready; // slot free or drained this cycle.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (req_ready) begin
            out.valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            out.addr       <= sum;
            out.op         <= req_op;
            out.wdata      <= req_wdata;
            out.tag        <= req_tag;
            out.misaligned <= misaligned;
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic      clk,
    input  logic      rst,
    mem_req_if.sink   req,
    mem_rsp_if.source rsp,
    axi_if.master     axi
);

    typedef enum logic [1:0] {idle, addr, resp, done} lsu_state_e;

    lsu_state_e           state;
    logic                 store_q;
    mem_types_pkg::addr_t acc_addr;
    axi_pkg::axi_size_t   acc_size;
    mem_types_pkg::data_t wdata_q;
    axi_pkg::axi_strb_t   strb_q;
    logic                 req_store;
    axi_pkg::axi_size_t   req_size;
    logic                 addr_done;
    logic                 rsp_take;
    logic                 resp_err;

    always_comb begin
        req_store = 1'b0;
        case (req.op)
            mem_types_pkg::op_lb, mem_types_pkg::op_lbu: req_size = axi_pkg::SIZE_BYTE;
            mem_types_pkg::op_lh, mem_types_pkg::op_lhu: req_size = axi_pkg::SIZE_HALF;
            mem_types_pkg::op_sb: begin
                req_size  = axi_pkg::SIZE_BYTE;
                req_store = 1'b1;
            end
            mem_types_pkg::op_sh: begin
                req_size  = axi_pkg::SIZE_HALF;
                req_store = 1'b1;
            end
            mem_types_pkg::op_sw: begin
                req_size  = axi_pkg::SIZE_WORD;
                req_store = 1'b1;
            end
            default: req_size = axi_pkg::SIZE_WORD;
        endcase
    end

    assign req.ready = (state == idle);
    assign rsp.valid = (state == done);

    assign axi.awaddr  = acc_addr;
    assign axi.araddr  = acc_addr;
    assign axi.awid    = axi_pkg::LSU_AXI_ID;
    assign axi.arid    = axi_pkg::LSU_AXI_ID;
    assign axi.awlen   = axi_pkg::LEN_SINGLE;
    assign axi.arlen   = axi_pkg::LEN_SINGLE;
    assign axi.awsize  = acc_size;
    assign axi.arsize  = acc_size;
    assign axi.awburst = axi_pkg::BURST_INCR;
    assign axi.arburst = axi_pkg::BURST_INCR;
    assign axi.wdata   = wdata_q;
    assign axi.wstrb   = strb_q;
    assign axi.wlast   = 1'b1;
    assign axi.bready  = (state == resp) && store_q;
    assign axi.rready  = (state == resp) && !store_q;

    // aw and w may complete in different cycles.
    assign addr_done = store_q ? ((!axi.awvalid || axi.awready) && (!axi.wvalid || axi.wready))
                               : axi.arready;
    assign rsp_take  = store_q ? (axi.bvalid && axi.bready) : (axi.rvalid && axi.rready);
    assign resp_err  = store_q ? (axi.bresp != axi_pkg::RESP_OKAY ||
                                  axi.bid != axi_pkg::LSU_AXI_ID)
                               : (axi.rresp != axi_pkg::RESP_OKAY ||
                                  axi.rid != axi_pkg::LSU_AXI_ID || !axi.rlast);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= idle;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.arvalid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req.valid && req.misaligned) begin
                        state <= done; // fault without touching the bus.
                    end else if (req.valid) begin
                        state       <= addr;
                        axi.awvalid <= req_store;
                        axi.wvalid  <= req_store;
                        axi.arvalid <= !req_store;
                    end
                end
                addr: begin
                    if (axi.awready) axi.awvalid <= 1'b0;
                    if (axi.wready)  axi.wvalid  <= 1'b0;
                    if (axi.arready) axi.arvalid <= 1'b0;
                    if (addr_done)   state <= resp;
                end
                resp: if (rsp_take) state <= done;
                done: if (rsp.ready) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            store_q    <= req_store;
            acc_addr   <= req.addr;
            acc_size   <= req_size;
            wdata_q    <= req.wdata << {req.addr[1:0], 3'b000};
            strb_q     <= (req_size == axi_pkg::SIZE_WORD) ? 4'b1111 :
                          (req_size == axi_pkg::SIZE_HALF) ? (4'b0011 << req.addr[1:0]) :
                                                             (4'b0001 << req.addr[1:0]);
            rsp.op     <= req.op;
            rsp.tag    <= req.tag;
            rsp.offset <= req.addr[1:0];
            rsp.rdata  <= '0;
            rsp.fault  <= req.misaligned;
        end else if (rsp_take) begin
            rsp.rdata  <= store_q ? '0 : axi.rdata;
            rsp.fault  <= resp_err;
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        axi.awvalid && !axi.awready |=> axi.awvalid && $stable(axi.awaddr));
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        axi.wvalid && !axi.wready |=> axi.wvalid && $stable(axi.wdata) && $stable(axi.wstrb));
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        axi.arvalid && !axi.arready |=> axi.arvalid && $stable(axi.araddr));
    a_one_dir: assert property (@(posedge clk) disable iff (rst)
        !(axi.arvalid && (axi.awvalid || axi.wvalid)));

endmodule

`default_nettype wire

// File: rtl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic                    clk,
    input  logic                    rst,
    mem_rsp_if.sink                 rsp,
    output logic                    wb_valid,
    input  logic                    wb_ready,
    output mem_types_pkg::data_t    wb_data,
    output mem_types_pkg::reg_tag_t wb_tag,
    output logic                    wb_fault
);

    mem_types_pkg::data_t shifted;
    mem_types_pkg::data_t ext;

    assign shifted = rsp.rdata >> {rsp.offset, 3'b000};

    always_comb begin
        case (rsp.op)
            mem_types_pkg::op_lb:  ext = {{24{shifted[7]}}, shifted[7:0]};
            mem_types_pkg::op_lbu: ext = {24'd0, shifted[7:0]};
            mem_types_pkg::op_lh:  ext = {{16{shifted[15]}}, shifted[15:0]};
            mem_types_pkg::op_lhu: ext = {16'd0, shifted[15:0]};
            mem_types_pkg::op_lw:  ext = shifted;
            default:               ext = '0; // stores write back nothing.
        endcase
    end

    assign rsp.ready = !wb_valid || wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (rsp.ready) begin
            wb_valid <= rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.valid && rsp.ready) begin
            wb_data  <= rsp.fault ? '0 : ext;
            wb_tag   <= rsp.tag;
            wb_fault <= rsp.fault;
        end
    end

    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_tag));

endmodule

`default_nettype wire

// File: rtl/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
    input  logic clk,
    input  logic rst,
    axi_if.slave axi
);

    mem_types_pkg::data_t     mem [mem_types_pkg::SRAM_WORDS];
    mem_types_pkg::addr_t     wr_offs;
    mem_types_pkg::addr_t     rd_offs;
    mem_types_pkg::sram_idx_t wr_idx;
    mem_types_pkg::sram_idx_t rd_idx;
    logic                     wr_hit;
    logic                     rd_hit;
    logic                     busy;
    logic                     wr_take;
    logic                     rd_take;

    assign wr_offs = axi.awaddr - mem_types_pkg::SRAM_BASE;
    assign rd_offs = axi.araddr - mem_types_pkg::SRAM_BASE;
    assign wr_hit  = wr_offs < mem_types_pkg::SRAM_BYTES; // wraps below base too.
    assign rd_hit  = rd_offs < mem_types_pkg::SRAM_BYTES;
    assign wr_idx  = wr_offs[mem_types_pkg::SRAM_IDX_W+1:2];
    assign rd_idx  = rd_offs[mem_types_pkg::SRAM_IDX_W+1:2];

    assign busy    = axi.awready || axi.arready || axi.bvalid || axi.rvalid;
    assign wr_take = axi.awvalid && axi.awready;
    assign rd_take = axi.arvalid && axi.arready;

    assign axi.wready = axi.awready; // w is taken with aw.
    assign axi.rlast  = axi.rvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axi.awready <= 1'b0;
            axi.arready <= 1'b0;
            axi.bvalid  <= 1'b0;
            axi.rvalid  <= 1'b0;
        end else begin
            axi.awready <= !busy && axi.awvalid && axi.wvalid;
            axi.arready <= !busy && axi.arvalid && !axi.awvalid;
            if (wr_take) begin
                axi.bvalid <= 1'b1;
            end else if (axi.bready) begin
                axi.bvalid <= 1'b0;
            end
            if (rd_take) begin
                axi.rvalid <= 1'b1;
            end else if (axi.rready) begin
                axi.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_hit && axi.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= axi.wdata[8*i +: 8];
                end
            end
            axi.bid   <= axi.awid;
            axi.bresp <= wr_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
        if (rd_take) begin
            axi.rid   <= axi.arid;
            axi.rresp <= rd_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            axi.rdata <= rd_hit ? mem[rd_idx] : '0;
        end
    end

    a_aw_single: assert property (@(posedge clk) disable iff (rst)
        wr_take |-> axi.awlen == axi_pkg::LEN_SINGLE && axi.awburst == axi_pkg::BURST_INCR &&
                    axi.awsize <= axi_pkg::SIZE_WORD && axi.wvalid && axi.wlast);
    a_ar_single: assert property (@(posedge clk) disable iff (rst)
        rd_take |-> axi.arlen == axi_pkg::LEN_SINGLE && axi.arburst == axi_pkg::BURST_INCR &&
                    axi.arsize <= axi_pkg::SIZE_WORD);

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  mem_types_pkg::mem_op_e  req_op,
    input  mem_types_pkg::data_t    req_base,
    input  mem_types_pkg::data_t    req_offset,
    input  mem_types_pkg::data_t    req_wdata,
    input  mem_types_pkg::reg_tag_t req_tag,
    output logic                    wb_valid,
    input  logic                    wb_ready,
    output mem_types_pkg::data_t    wb_data,
    output mem_types_pkg::reg_tag_t wb_tag,
    output logic                    wb_fault
);

    mem_req_if req_bus ();
    mem_rsp_if rsp_bus ();
    axi_if     axi_bus ();

    agu u_agu (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .req_tag    (req_tag),
        .out        (req_bus.source)
    );

    lsu u_lsu (
        .clk (clk),
        .rst (rst),
        .req (req_bus.sink),
        .rsp (rsp_bus.source),
        .axi (axi_bus.master)
    );

    load_align u_load_align (
        .clk      (clk),
        .rst      (rst),
        .rsp      (rsp_bus.sink),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .wb_tag   (wb_tag),
        .wb_fault (wb_fault)
    );

    axi_sram u_axi_sram (
        .clk (clk),
        .rst (rst),
        .axi (axi_bus.slave)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int TIMEOUT_CYCLES = 20000; // about 500 accesses of ~6 cycles.
    localparam int RAND_ACCESSES  = 200;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    logic                    req_ready;
    mem_types_pkg::mem_op_e  req_op;
    mem_types_pkg::data_t    req_base;
    mem_types_pkg::data_t    req_offset;
    mem_types_pkg::data_t    req_wdata;
    mem_types_pkg::reg_tag_t req_tag;
    logic                    wb_valid;
    logic                    wb_ready;
    mem_types_pkg::data_t    wb_data;
    mem_types_pkg::reg_tag_t wb_tag;
    logic                    wb_fault;

    logic [7:0]              shadow [mem_types_pkg::SRAM_WORDS*4]; // byte image of the sram.
    mem_types_pkg::data_t    exp_data [$];
    mem_types_pkg::reg_tag_t exp_tag [$];
    logic                    exp_fault [$];
    logic [15:0]             lfsr_q;
    int                      cyc;
    int                      tag_cnt;
    int                      wb_mode; // 0 always ready, 1 held low, 2 masked pattern.
    logic [3:0]              wb_mask;

    mem_subsys_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .req_tag    (req_tag),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_data    (wb_data),
        .wb_tag     (wb_tag),
        .wb_fault   (wb_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11+1.
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mem_types_pkg::data_t fill_word(input mem_types_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    // reference behavior of one access, applied to the shadow image.
    task automatic model_access(input mem_types_pkg::mem_op_e op, input mem_types_pkg::addr_t a,
                                input mem_types_pkg::data_t wd, output mem_types_pkg::data_t d,
                                output logic f);
        logic [31:0] offs;
        int          nbytes;
        logic        is_store;
        logic [31:0] v;
        offs     = a - mem_types_pkg::SRAM_BASE;
        is_store = (op == mem_types_pkg::op_sb) || (op == mem_types_pkg::op_sh) ||
                   (op == mem_types_pkg::op_sw);
        case (op)
            mem_types_pkg::op_lb, mem_types_pkg::op_lbu, mem_types_pkg::op_sb: nbytes = 1;
            mem_types_pkg::op_lh, mem_types_pkg::op_lhu, mem_types_pkg::op_sh: nbytes = 2;
            default: nbytes = 4;
        endcase
        f = ((a[1:0] & 2'(nbytes - 1)) != 2'b00) || (offs >= mem_types_pkg::SRAM_WORDS * 4);
        d = '0;
        v = '0;
        if (!f) begin
            for (int i = 0; i < nbytes; i++) begin
                if (is_store) shadow[offs + i] = wd[8*i +: 8];
                else          v[8*i +: 8] = shadow[offs + i];
            end
            if (op == mem_types_pkg::op_lb) v = {{24{v[7]}}, v[7:0]};
            if (op == mem_types_pkg::op_lh) v = {{16{v[15]}}, v[15:0]};
            if (!is_store) d = v;
        end
    endtask

    // called 2 ns after a rising edge, returns at the same phase.
    task automatic send_req(input mem_types_pkg::mem_op_e op, input mem_types_pkg::data_t base,
                            input mem_types_pkg::data_t offs, input mem_types_pkg::data_t wd);
        mem_types_pkg::data_t d;
        logic                 f;
        req_valid  = 1'b1;
        req_op     = op;
        req_base   = base;
        req_offset = offs;
        req_wdata  = wd;
        req_tag    = tag_cnt[4:0];
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        model_access(op, base + offs, wd, d, f);
        exp_data.push_back(d);
        exp_tag.push_back(tag_cnt[4:0]);
        exp_fault.push_back(f);
        tag_cnt++;
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) @(posedge clk);
        #2;
    endtask

    task automatic test_fill();
        for (int w = 0; w < mem_types_pkg::SRAM_WORDS; w++) begin
            send_req(mem_types_pkg::op_sw, mem_types_pkg::SRAM_BASE, w * 4,
                     fill_word(mem_types_pkg::SRAM_BASE + w * 4));
        end
        wait_drain();
    endtask

    task automatic test_word_roundtrip();
        send_req(mem_types_pkg::op_sw, mem_types_pkg::SRAM_BASE + 4, 32'd4, 32'hDEAD_BEEF);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'd8, 32'h0);
        wait_drain();
    endtask

    task automatic test_byte_half();
        for (int i = 0; i < 4; i++) send_req(mem_types_pkg::op_sb, mem_types_pkg::SRAM_BASE,
                                             32'h10 + i, 32'h0000_0079 + 32'h11 * i);
        send_req(mem_types_pkg::op_sh, mem_types_pkg::SRAM_BASE, 32'h14, 32'h1234_8001);
        send_req(mem_types_pkg::op_sh, mem_types_pkg::SRAM_BASE, 32'h16, 32'h0000_7FFE);
        for (int i = 0; i < 4; i++) begin
            send_req(mem_types_pkg::op_lb, mem_types_pkg::SRAM_BASE, 32'h10 + i, 32'h0);
            send_req(mem_types_pkg::op_lbu, mem_types_pkg::SRAM_BASE, 32'h10 + i, 32'h0);
        end
        for (int i = 0; i < 4; i += 2) begin
            send_req(mem_types_pkg::op_lh, mem_types_pkg::SRAM_BASE, 32'h14 + i, 32'h0);
            send_req(mem_types_pkg::op_lhu, mem_types_pkg::SRAM_BASE, 32'h14 + i, 32'h0);
        end
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h10, 32'h0);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h14, 32'h0);
        wait_drain();
    endtask

    task automatic test_misaligned();
        send_req(mem_types_pkg::op_sh, mem_types_pkg::SRAM_BASE, 32'h21, 32'hFFFF_FFFF);
        send_req(mem_types_pkg::op_sw, mem_types_pkg::SRAM_BASE, 32'h22, 32'hFFFF_FFFF);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h23, 32'h0);
        send_req(mem_types_pkg::op_lhu, mem_types_pkg::SRAM_BASE, 32'h11, 32'h0);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h20, 32'h0);
        wait_drain();
    endtask

    task automatic test_out_of_window();
        send_req(mem_types_pkg::op_lw, 32'h7FFF_FFF0, 32'hC, 32'h0); // just below the window.
        send_req(mem_types_pkg::op_sw, mem_types_pkg::SRAM_BASE, 32'h400, 32'h0BAD_0BAD);
        send_req(mem_types_pkg::op_sb, 32'h0000_0000, 32'h0, 32'h0000_00AA);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h0, 32'h0);
        send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE, 32'h3FC, 32'h0);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int low_cnt;
        wb_mode = 1;
        @(posedge clk);
        #2;
        for (int i = 0; i < 3; i++) send_req(mem_types_pkg::op_lw, mem_types_pkg::SRAM_BASE,
                                             32'h40 + 4 * i, 32'h0);
        low_cnt = 0;
        for (int i = 0; i < 50 && low_cnt < 16; i++) begin
            @(negedge clk);
            if (req_ready) low_cnt = 0;
            else low_cnt++;
        end
        assert (low_cnt >= 16) // longer than any single access.
            else report_fail("req_ready did not stay low while writeback was held off");
        @(posedge clk);
        #2;
        wb_mask = 4'b0101;
        wb_mode = 2;
        for (int i = 0; i < 3; i++) send_req(mem_types_pkg::op_lhu, mem_types_pkg::SRAM_BASE,
                                             32'h50 + 2 * i, 32'h0);
        wait_drain();
        wb_mode = 0;
    endtask

    task automatic test_random();
        mem_types_pkg::mem_op_e op;
        mem_types_pkg::addr_t   a;
        mem_types_pkg::data_t   offs;
        mem_types_pkg::data_t   wd;
        wb_mode = 2;
        for (int n = 0; n < RAND_ACCESSES; n++) begin
            op      = mem_types_pkg::mem_op_e'(3'(lfsr_take(3)));
            a       = mem_types_pkg::SRAM_BASE + (lfsr_take(6) << 2) + lfsr_take(2);
            offs    = lfsr_take(6) - 32'd32; // offsets between -32 and 31.
            wd      = lfsr_take(32);
            wb_mask = 4'(lfsr_take(4)) | 4'b0001; // at least one ready slot.
            send_req(op, a - offs, offs, wd);
        end
        wait_drain();
        wb_mode = 0;
    endtask

    always @(posedge clk) begin
        #2;
        case (wb_mode)
            0:       wb_ready = 1'b1;
            1:       wb_ready = 1'b0;
            default: wb_ready = wb_mask[cyc[1:0]];
        endcase
    end

    // a transfer seen here completes on the next rising edge.
    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            assert (exp_data.size() != 0)
                else report_fail("a writeback arrived with no request outstanding");
            assert (wb_data === exp_data[0] && wb_tag === exp_tag[0] &&
                    wb_fault === exp_fault[0])
                else report_fail($sformatf(
                    "Mismatch at %0t: got data %h tag %0d fault %b, expected %h tag %0d fault %b",
                    $time, wb_data, wb_tag, wb_fault, exp_data[0], exp_tag[0], exp_fault[0]));
            void'(exp_data.pop_front());
            void'(exp_tag.pop_front());
            void'(exp_fault.pop_front());
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= TIMEOUT_CYCLES) report_fail("The run took too long and was stopped");
    end

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = mem_types_pkg::op_lw;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        req_tag    = '0;
        wb_ready   = 1'b0;
        wb_mode    = 0;
        wb_mask    = 4'b1111;
        lfsr_q     = 16'd53;
        cyc        = 0;
        tag_cnt    = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (!wb_valid) else report_fail("wb_valid was high right after reset");
        test_fill();
        test_word_roundtrip();
        test_byte_half();
        test_misaligned();
        test_out_of_window();
        test_backpressure();
        test_random();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/mem_types_pkg.sv
rtl/axi_pkg.sv
rtl/axi_if.sv
rtl/mem_stage_ifs.sv
rtl/agu.sv
rtl/lsu.sv
rtl/load_align.sv
rtl/axi_sram.sv
rtl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv
